/* hw/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Width of the data path and of one instruction word
`define XLEN 32

// Register index width, giving 32 architectural registers
`define REG_ADDR_W 5

// Instruction memory is word addressed
`define IMEM_ADDR_W 8

// Data memory is word addressed as well
`define DMEM_ADDR_W 8

`endif

/* hw/cpuPkg.sv */
`include "cpu_macros.svh"

package cpuPkg;

	// Primary opcodes in bits 31:26 of the instruction
	typedef enum logic [5:0] {
		opRType = 6'b000000,
		opJ     = 6'b000010,
		opBne   = 6'b000101,
		opLi    = 6'b001001,
		opXori  = 6'b001110,
		opLw    = 6'b100011,
		opSw    = 6'b101011
	} opcodeE;

	// Function codes of the R-type group in bits 5:0
	typedef enum logic [5:0] {
		funcAdd = 6'b100000,
		funcSub = 6'b100010,
		funcSlt = 6'b101010
	} funcE;

	// Operation selected in execute with aluNone as the bubble encoding
	typedef enum logic [2:0] {
		aluNone,
		aluAdd,
		aluSub,
		aluSlt,
		aluXor,
		aluImm
	} aluOpE;

	typedef struct packed {
		logic                    valid;
		logic [`XLEN-1:0]        instr;
		logic [`IMEM_ADDR_W-1:0] pc;
	} ifIdT;

	typedef struct packed {
		logic                    valid;
		aluOpE                   aluOp;
		logic [`XLEN-1:0]        rsVal;
		logic [`XLEN-1:0]        rtVal;
		logic [`XLEN-1:0]        imm;
		logic [`REG_ADDR_W-1:0]  rs;
		logic [`REG_ADDR_W-1:0]  rt;
		logic [`REG_ADDR_W-1:0]  rd;
		logic                    regWrite;
		logic                    load;
		logic                    store;
		logic                    branch;
		logic [`IMEM_ADDR_W-1:0] branchTarget;
	} idExT;

	typedef struct packed {
		logic                   valid;
		logic [`XLEN-1:0]       result;
		logic [`XLEN-1:0]       storeData;
		logic [`REG_ADDR_W-1:0] rd;
		logic                   regWrite;
		logic                   load;
		logic                   store;
	} exMemT;

	typedef struct packed {
		logic                   we;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`XLEN-1:0]       data;
	} wbT;

	typedef struct packed {
		logic                    take;
		logic [`IMEM_ADDR_W-1:0] target;
	} redirectT;

endpackage

/* hw/fetchStage.sv */
`include "cpu_macros.svh"

module fetchStage (
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    run,
	input  logic                    imemWe,
	input  logic [`IMEM_ADDR_W-1:0] imemAddr,
	input  logic [`XLEN-1:0]        imemData,
	input  logic                    stall,
	input  cpuPkg::redirectT        jumpRedirect,
	input  cpuPkg::redirectT        branchRedirect,
	output cpuPkg::ifIdT            ifId
);

	localparam int imemDepth = 1 << `IMEM_ADDR_W;

	logic [`XLEN-1:0]        imem [imemDepth];
	logic [`IMEM_ADDR_W-1:0] pc;

	// The program load port is only used while the core is halted
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	// A branch resolves in execute and is older than a jump in decode, so it wins
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			ifId <= '0;
		end else if (branchRedirect.take) begin
			pc <= branchRedirect.target;
			ifId.valid <= 1'b0;
		end else if (jumpRedirect.take) begin
			pc <= jumpRedirect.target;
			ifId.valid <= 1'b0;
		end else if (!stall) begin
			if (run) begin
				pc <= pc + 1'b1;
				ifId.valid <= 1'b1;
				ifId.instr <= imem[pc];
				ifId.pc <= pc;
			end else begin
				// Halted, so keep the PC and feed bubbles
				ifId.valid <= 1'b0;
			end
		end
	end

	// Loading the program under a running core would race with fetch
	loadWhileHalted: assert property (@(posedge clk) disable iff (!rstN)
		!(imemWe && run));

endmodule

/* hw/decodeStage.sv */
`include "cpu_macros.svh"

module decodeStage (
	input  logic             clk,
	input  logic             rstN,
	input  cpuPkg::ifIdT     ifId,
	input  cpuPkg::redirectT branchRedirect,
	input  cpuPkg::wbT       wb,
	output cpuPkg::idExT     idEx,
	output cpuPkg::redirectT jumpRedirect,
	output logic             stall
);
	import cpuPkg::*;

	localparam int regCount = 1 << `REG_ADDR_W;

	logic [`XLEN-1:0]       regFile [regCount];
	opcodeE                 opcode;
	funcE                   func;
	logic [`REG_ADDR_W-1:0] rs;
	logic [`REG_ADDR_W-1:0] rt;
	logic [`REG_ADDR_W-1:0] rd;
	logic [`XLEN-1:0]       imm;
	logic                   usesRs;
	logic                   usesRt;
	idExT                   idExD;

	assign opcode = opcodeE'(ifId.instr[31:26]);
	assign func = funcE'(ifId.instr[5:0]);
	assign rs = ifId.instr[25:21];
	assign rt = ifId.instr[20:16];
	assign rd = ifId.instr[15:11];
	assign imm = {{(`XLEN - 16){ifId.instr[15]}}, ifId.instr[15:0]};

	always_ff @(posedge clk) begin
		if (wb.we) begin
			regFile[wb.rd] <= wb.data;
		end
	end

	// Register 0 reads as zero, and a write in flight this cycle is seen at once
	function automatic logic [`XLEN-1:0] readReg(input logic [`REG_ADDR_W-1:0] idx);
		if (idx == '0) begin
			return '0;
		end else if (wb.we && wb.rd == idx) begin
			return wb.data;
		end
		return regFile[idx];
	endfunction

	always_comb begin
		idExD = '0;
		idExD.valid = ifId.valid;
		idExD.aluOp = aluNone;
		idExD.rsVal = readReg(rs);
		idExD.rtVal = readReg(rt);
		idExD.imm = imm;
		idExD.rs = rs;
		idExD.rt = rt;
		idExD.rd = rt;
		idExD.branchTarget = ifId.pc + 1'b1 + imm[`IMEM_ADDR_W-1:0];
		usesRs = 1'b0;
		usesRt = 1'b0;
		if (ifId.valid) begin
			case (opcode)
				opRType: begin
					usesRs = 1'b1;
					usesRt = 1'b1;
					idExD.rd = rd;
					idExD.regWrite = 1'b1;
					case (func)
						funcAdd: idExD.aluOp = aluAdd;
						funcSub: idExD.aluOp = aluSub;
						funcSlt: idExD.aluOp = aluSlt;
						default: idExD.regWrite = 1'b0;
					endcase
				end
				opLi: begin
					idExD.aluOp = aluImm;
					idExD.regWrite = 1'b1;
				end
				opXori: begin
					usesRs = 1'b1;
					idExD.aluOp = aluXor;
					idExD.regWrite = 1'b1;
				end
				opLw: begin
					usesRs = 1'b1;
					idExD.aluOp = aluAdd;
					idExD.load = 1'b1;
					idExD.regWrite = 1'b1;
				end
				opSw: begin
					usesRs = 1'b1;
					usesRt = 1'b1;
					idExD.aluOp = aluAdd;
					idExD.store = 1'b1;
				end
				opBne: begin
					usesRs = 1'b1;
					usesRt = 1'b1;
					idExD.branch = 1'b1;
				end
				default: idExD.aluOp = aluNone;
			endcase
		end
	end

	// Load data only exists after the memory stage, so a dependent instruction waits a cycle
	assign stall = idEx.valid && idEx.load && idEx.rd != '0 &&
		((usesRs && idEx.rd == rs) || (usesRt && idEx.rd == rt));

	// A J on the wrong path of a taken branch must not redirect
	assign jumpRedirect.take = ifId.valid && opcode == opJ && !branchRedirect.take;
	assign jumpRedirect.target = ifId.instr[`IMEM_ADDR_W-1:0];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			idEx <= '0;
		end else if (stall || branchRedirect.take) begin
			idEx <= '0;
		end else begin
			idEx <= idExD;
		end
	end

	redirectFromValid: assert property (@(posedge clk) disable iff (!rstN)
		(stall || jumpRedirect.take) |-> ifId.valid);

endmodule

/* hw/executeStage.sv */
`include "cpu_macros.svh"

module executeStage (
	input  logic             clk,
	input  logic             rstN,
	input  cpuPkg::idExT     idEx,
	input  cpuPkg::wbT       wb,
	output cpuPkg::exMemT    exMem,
	output cpuPkg::redirectT branchRedirect
);
	import cpuPkg::*;

	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] rtFwd;
	logic [`XLEN-1:0] aluResult;

	// The memory stage holds the newer value, so it is checked before writeback
	function automatic logic [`XLEN-1:0] fwdOperand(
		input logic [`REG_ADDR_W-1:0] idx,
		input logic [`XLEN-1:0]       decoded,
		input exMemT                  memSrc,
		input wbT                     wbSrc
	);
		if (idx == '0) begin
			return decoded;
		end else if (memSrc.valid && memSrc.regWrite && !memSrc.load && memSrc.rd == idx) begin
			return memSrc.result;
		end else if (wbSrc.we && wbSrc.rd == idx) begin
			return wbSrc.data;
		end
		return decoded;
	endfunction

	assign opA = fwdOperand(idEx.rs, idEx.rsVal, exMem, wb);
	assign rtFwd = fwdOperand(idEx.rt, idEx.rtVal, exMem, wb);

	// Loads and stores add the offset to the base register
	assign opB = (idEx.load || idEx.store) ? idEx.imm : rtFwd;

	always_comb begin
		case (idEx.aluOp)
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluSlt: aluResult = {{(`XLEN - 1){1'b0}}, $signed(opA) < $signed(opB)};
			aluXor: aluResult = opA ^ idEx.imm;
			aluImm: aluResult = idEx.imm;
			default: aluResult = '0;
		endcase
	end

	assign branchRedirect.take = idEx.valid && idEx.branch && (opA != rtFwd);
	assign branchRedirect.target = idEx.branchTarget;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exMem <= '0;
		end else begin
			exMem.valid <= idEx.valid;
			exMem.result <= aluResult;
			exMem.storeData <= rtFwd;
			exMem.rd <= idEx.rd;
			exMem.regWrite <= idEx.regWrite;
			exMem.load <= idEx.load;
			exMem.store <= idEx.store;
		end
	end

	// Decode sets at most one memory flag per instruction
	oneMemAccess: assert property (@(posedge clk) disable iff (!rstN)
		!(exMem.load && exMem.store));

endmodule

/* hw/memWbStage.sv */
`include "cpu_macros.svh"

module memWbStage (
	input  logic          clk,
	input  logic          rstN,
	input  cpuPkg::exMemT exMem,
	output cpuPkg::wbT    wb
);

	localparam int dmemDepth = 1 << `DMEM_ADDR_W;

	logic [`XLEN-1:0]        dmem [dmemDepth];
	logic [`DMEM_ADDR_W-1:0] addr;

	// Word address taken from the low bits of the computed address
	assign addr = exMem.result[`DMEM_ADDR_W-1:0];

	always_ff @(posedge clk) begin
		if (exMem.valid && exMem.store) begin
			dmem[addr] <= exMem.storeData;
		end
	end

	// The wb register drives the register file write in the following cycle
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wb <= '0;
		end else begin
			wb.we <= exMem.valid && exMem.regWrite;
			wb.rd <= exMem.rd;
			wb.data <= exMem.load ? dmem[addr] : exMem.result;
		end
	end

endmodule

/* hw/pipelinedCpu.sv */
`include "cpu_macros.svh"

module pipelinedCpu (
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    run,
	input  logic                    imemWe,
	input  logic [`IMEM_ADDR_W-1:0] imemAddr,
	input  logic [`XLEN-1:0]        imemData,
	output logic                    wbValid,
	output logic [`REG_ADDR_W-1:0]  wbReg,
	output logic [`XLEN-1:0]        wbData
);
	import cpuPkg::*;

	ifIdT     ifId;
	idExT     idEx;
	exMemT    exMem;
	wbT       wb;
	redirectT jumpRedirect;
	redirectT branchRedirect;
	logic     stall;

	fetchStage fetch (
		.clk           (clk),
		.rstN          (rstN),
		.run           (run),
		.imemWe        (imemWe),
		.imemAddr      (imemAddr),
		.imemData      (imemData),
		.stall         (stall),
		.jumpRedirect  (jumpRedirect),
		.branchRedirect(branchRedirect),
		.ifId          (ifId)
	);

	decodeStage decode (
		.clk           (clk),
		.rstN          (rstN),
		.ifId          (ifId),
		.branchRedirect(branchRedirect),
		.wb            (wb),
		.idEx          (idEx),
		.jumpRedirect  (jumpRedirect),
		.stall         (stall)
	);

	executeStage execute (
		.clk           (clk),
		.rstN          (rstN),
		.idEx          (idEx),
		.wb            (wb),
		.exMem         (exMem),
		.branchRedirect(branchRedirect)
	);

	memWbStage memWb (
		.clk  (clk),
		.rstN (rstN),
		.exMem(exMem),
		.wb   (wb)
	);

	// Every register file write is visible on the trace port
	assign wbValid = wb.we;
	assign wbReg = wb.rd;
	assign wbData = wb.data;

endmodule

/* verif/cpuTb.sv */
`include "cpu_macros.svh"

module cpuTb;

	localparam int stimDepth = 64;
	localparam int cyclesPerWrite = 20;
	localparam int timeoutSlack = 100;

	logic                    clk;
	logic                    rstN;
	logic                    run;
	logic                    imemWe;
	logic [`IMEM_ADDR_W-1:0] imemAddr;
	logic [`XLEN-1:0]        imemData;
	logic                    wbValid;
	logic [`REG_ADDR_W-1:0]  wbReg;
	logic [`XLEN-1:0]        wbData;

	// Word count, program words, write count, then (register, value) pairs
	logic [`XLEN-1:0] stimMem [stimDepth];
	int               wordCount;
	int               writeCount;
	int               writesSeen;
	int               errorCount;
	int               cycleCount;
	int               cycleLimit;

	pipelinedCpu DUT (
		.clk     (clk),
		.rstN    (rstN),
		.run     (run),
		.imemWe  (imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.wbValid (wbValid),
		.wbReg   (wbReg),
		.wbData  (wbData)
	);

	always #4 clk = ~clk;

	task automatic resetCore();
		repeat (5) @(posedge clk);
		#1 rstN = 1'b1;
	endtask

	// The core stays halted while the program goes in through the load port
	task automatic loadProgram();
		for (int i = 0; i < wordCount; i++) begin
			@(posedge clk);
			#1;
			imemWe = 1'b1;
			imemAddr = i[`IMEM_ADDR_W-1:0];
			imemData = stimMem[1 + i];
			assert (!wbValid) else begin
				errorCount++;
				$display("A register write appeared while the core was halted at time %0t", $time);
			end
		end
		@(posedge clk);
		#1 imemWe = 1'b0;
	endtask

	task automatic checkWrite();
		logic [`REG_ADDR_W-1:0] expReg;
		logic [`XLEN-1:0]       expData;
		expReg = stimMem[wordCount + 2 + 2 * writesSeen][`REG_ADDR_W-1:0];
		expData = stimMem[wordCount + 3 + 2 * writesSeen];
		assert (wbReg == expReg) else begin
			errorCount++;
			$display("Error at time %0t: wbReg expected %0d, actual %0d", $time, expReg, wbReg);
		end
		assert (wbData == expData) else begin
			errorCount++;
			$display("Error at time %0t: wbData expected %h, actual %h", $time, expData, wbData);
		end
		writesSeen++;
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		errorCount = 0;
		writesSeen = 0;
		cycleCount = 0;
		$readmemh("verif/cpuStimulus.txt", stimMem);
		wordCount = $isunknown(stimMem[0]) ? 0 : int'(stimMem[0]);
		writeCount = $isunknown(stimMem[wordCount + 1]) ? 0 : int'(stimMem[wordCount + 1]);
		assert (wordCount > 0 && writeCount > 0 && wordCount + 2 + 2 * writeCount <= stimDepth)
		else begin
			errorCount++;
			$display("The stimulus file is missing, empty or larger than the buffer");
			wordCount = 0;
			writeCount = 0;
		end
		cycleLimit = cyclesPerWrite * writeCount + timeoutSlack;

		resetCore();
		loadProgram();
		@(posedge clk);
		#1 run = 1'b1;

		// The trace register is updated on the rising edge, so it is read on the falling one
		while (writesSeen < writeCount && cycleCount < cycleLimit) begin
			@(negedge clk);
			cycleCount++;
			if (wbValid) begin
				checkWrite();
			end
		end
		if (writesSeen < writeCount) begin
			errorCount++;
			$display("Timeout after %0d cycles with only %0d of %0d expected writes seen",
				cycleCount, writesSeen, writeCount);
		end

		$display("%0d errors, %0d of %0d writes checked", errorCount, writesSeen, writeCount);
		if (errorCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* verif/cpuStimulus.txt */
// Word count in hex, then one instruction word per line
// Write count in hex, then one pair per line: register index, written value
14
24010007 // LI   r1, 7
2402FFFD // LI   r2, -3
00221820 // ADD  r3, r1, r2
00612022 // SUB  r4, r3, r1
0041282A // SLT  r5, r2, r1
AC230002 // SW   r3, 2(r1)
8C260002 // LW   r6, 2(r1)
00C13820 // ADD  r7, r6, r1
24080003 // LI   r8, 3
2409FFFF // LI   r9, -1
01094020 // ADD  r8, r8, r9
1500FFFE // BNE  r8, r0, -2
24001234 // LI   r0, 0x1234
00015820 // ADD  r11, r0, r1
384C00F0 // XORI r12, r2, 0x00f0
382D8001 // XORI r13, r1, 0x8001
08000012 // J    18
240E0BAD // LI   r14, 0xbad
240F0099 // LI   r15, 0x99
08000013 // J    19
11
01 00000007
02 FFFFFFFD
03 00000004
04 FFFFFFFD
05 00000001
06 00000004
07 0000000B
08 00000003
09 FFFFFFFF
08 00000002
08 00000001
08 00000000
00 00001234
0B 00000007
0C FFFFFF0D
0D FFFF8006
0F 00000099

/* sim.f */
+incdir+hw
hw/cpuPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memWbStage.sv
hw/pipelinedCpu.sv
verif/cpuTb.sv

/* Bender.yml */
package:
  name: pipelined_cpu

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpuPkg.sv
      - hw/fetchStage.sv
      - hw/decodeStage.sv
      - hw/executeStage.sv
      - hw/memWbStage.sv
      - hw/pipelinedCpu.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/cpuTb.sv
